// File: common/pokey_defines.svh
`ifndef POKEY_DEFINES_SVH
`define POKEY_DEFINES_SVH

// paddle lines wired to the port
`define POKEY_POT_COUNT 2

// pot counter stops here, one full line time
`define POKEY_POT_LIMIT 228

// depth of the host key event buffer
`define POKEY_KEY_CREDITS 2

// read side of the register map
`define POKEY_ADDR_POT0   4'h0
`define POKEY_ADDR_POT1   4'h1
`define POKEY_ADDR_ALLPOT 4'h8
`define POKEY_ADDR_KBCODE 4'h9
`define POKEY_ADDR_SKSTAT 4'hF

// write side, shares offsets with the read side
`define POKEY_ADDR_SKRES  4'hA
`define POKEY_ADDR_POTGO  4'hB
`define POKEY_ADDR_SKCTL  4'hF

`endif

// File: common/pokey_bus_pkg.sv
`include "pokey_defines.svh"

package pokey_bus_pkg;

	// registers seen by a host read
	typedef enum logic [3:0] {
		RD_POT0   = `POKEY_ADDR_POT0,
		RD_POT1   = `POKEY_ADDR_POT1,
		RD_ALLPOT = `POKEY_ADDR_ALLPOT,
		RD_KBCODE = `POKEY_ADDR_KBCODE,
		RD_SKSTAT = `POKEY_ADDR_SKSTAT
	} rd_reg_e;

	// registers seen by a host write
	typedef enum logic [3:0] {
		WR_SKRES = `POKEY_ADDR_SKRES,
		WR_POTGO = `POKEY_ADDR_POTGO,
		WR_SKCTL = `POKEY_ADDR_SKCTL
	} wr_reg_e;

	// same 4 address pins, meaning set by rw
	// 0xF is SKSTAT on read and SKCTL on write
	typedef union packed {
		rd_reg_e rd;
		wr_reg_e wr;
	} reg_addr_u;

	// one-cycle host strobe
	typedef struct packed {
		logic       sel;    // request valid this cycle
		logic       we;     // 1 write, 0 read
		reg_addr_u  addr;
		logic [7:0] wdata;
	} bus_req_t;

endpackage

// File: common/pokey_ctrl_pkg.sv
package pokey_ctrl_pkg;

	// accepted key, handed to the host
	typedef struct packed {
		logic       shift;  // side button 0 at accept time
		logic [5:0] code;   // matrix scan code
	} key_evt_t;

	// decode to scanner controls
	typedef struct packed {
		logic key_en;  // level from SKCTL bit 0
		logic skres;   // strobe, clears status
		logic potgo;   // strobe, restarts pot counters
	} scan_ctl_t;

endpackage

// File: logic/pokey_reg_decode.sv
module pokey_reg_decode (
	input  logic                      o2,
	input  logic                      arst_n,
	input  pokey_bus_pkg::bus_req_t   bus,
	output pokey_ctrl_pkg::scan_ctl_t scan_ctl,
	output pokey_bus_pkg::rd_reg_e    rd_sel
);

	logic wr_req;
	logic rd_req;
	logic key_en;  // SKCTL bit 0
	logic skres_hit;
	logic potgo_hit;

	assign wr_req = bus.sel & bus.we;
	assign rd_req = bus.sel & ~bus.we;

	// write side of the address union
	assign skres_hit = wr_req && (bus.addr.wr == pokey_bus_pkg::WR_SKRES);
	assign potgo_hit = wr_req && (bus.addr.wr == pokey_bus_pkg::WR_POTGO);

	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			key_en <= 1'b1;  // scanning on out of reset
			rd_sel <= pokey_bus_pkg::RD_POT0;
		end else begin
			if (wr_req && bus.addr.wr == pokey_bus_pkg::WR_SKCTL)
				key_en <= bus.wdata[0];
			// read side of the union, held until the next read
			if (rd_req)
				rd_sel <= bus.addr.rd;
		end
	end

	// strobes act on the same edge the write is sampled
	assign scan_ctl.key_en = key_en;
	assign scan_ctl.skres  = skres_hit;
	assign scan_ctl.potgo  = potgo_hit;

	// a read of 0xF must never act as an SKCTL write
	a_read_no_write: assert property (
		@(posedge o2) disable iff (!arst_n)
		(bus.sel && !bus.we) |=> $stable(key_en)
	) else $error("key enable changed on a read request");

endmodule

// File: keyboard/pokey_key_scan.sv
`include "pokey_defines.svh"

module pokey_key_scan (
	input  logic                      o2,
	input  logic                      arst_n,
	input  pokey_ctrl_pkg::scan_ctl_t scan_ctl,
	input  logic                      kr1_n,       // low when the scanned key is down
	input  logic                      shift_n,     // side button 0
	input  logic                      key_credit,  // host freed one slot
	output logic [5:0]                key_scan,
	output logic [7:0]                kbcode,
	output logic [7:0]                skstat,
	output logic                      key_evt_valid,
	output pokey_ctrl_pkg::key_evt_t  key_evt
);

	localparam int CRED_W = $clog2(`POKEY_KEY_CREDITS + 1);
	localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`POKEY_KEY_CREDITS);

	logic [1:0]               hit_cnt;    // low codes this pass, sticks at 2
	logic [5:0]               hit_code;   // first low code this pass
	logic [1:0]               pass_cnt;
	logic [5:0]               pass_code;
	logic                     cmp_vld;    // last pass found exactly one key
	logic [5:0]               cmp_code;   // compare latch
	logic                     key_depr;
	logic                     overrun;
	pokey_ctrl_pkg::key_evt_t key_latch;  // keycode latch
	logic [CRED_W-1:0]        credit_cnt;
	logic [CRED_W-1:0]        credit_nxt;
	logic                     hit;
	logic                     pass_end;
	logic                     accept;
	logic                     send;

	assign hit       = scan_ctl.key_en & ~kr1_n;
	// include the sample taken on this edge, code 63 ends the pass
	assign pass_cnt  = (hit && hit_cnt != 2'd2) ? hit_cnt + 2'd1 : hit_cnt;
	assign pass_code = (hit && hit_cnt == 2'd0) ? key_scan : hit_code;
	assign pass_end  = scan_ctl.key_en && (key_scan == 6'd63);

	// second matching pass, and not the key already latched and held
	assign accept = pass_end && (pass_cnt == 2'd1) && cmp_vld
		&& (cmp_code == pass_code)
		&& !(key_depr && key_latch.code == pass_code);
	assign send = accept && (credit_cnt != '0);

	always_comb begin
		credit_nxt = credit_cnt;
		if (send && !key_credit)
			credit_nxt = credit_cnt - 1'b1;
		else if (!send && key_credit && credit_cnt != CRED_MAX)
			credit_nxt = credit_cnt + 1'b1;  // extra returns dropped at max
	end

	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			key_scan      <= '0;
			hit_cnt       <= '0;
			cmp_vld       <= 1'b0;
			key_depr      <= 1'b0;
			overrun       <= 1'b0;
			key_latch     <= '0;
			credit_cnt    <= CRED_MAX;
			key_evt_valid <= 1'b0;
		end else begin
			credit_cnt    <= credit_nxt;
			key_evt_valid <= send;
			if (scan_ctl.key_en)
				key_scan <= key_scan + 6'd1;  // wraps 63 to 0
			if (pass_end) begin
				hit_cnt <= '0;
				cmp_vld <= (pass_cnt == 2'd1);  // ghosting or no key restarts compare
				if (pass_cnt == 2'd0)
					key_depr <= 1'b0;  // clean pass, key released
			end else if (scan_ctl.key_en) begin
				hit_cnt <= pass_cnt;
			end
			if (accept) begin
				key_depr        <= 1'b1;
				key_latch.code  <= pass_code;
				key_latch.shift <= ~shift_n;
			end
			// set beats clear on a shared edge
			if (accept && credit_cnt == '0)
				overrun <= 1'b1;
			else if (scan_ctl.skres)
				overrun <= 1'b0;
		end
	end

	// codes for the two-pass compare
	always_ff @(posedge o2) begin
		if (pass_end || scan_ctl.key_en)
			hit_code <= pass_code;
		if (pass_end)
			cmp_code <= pass_code;
	end

	assign key_evt = key_latch;
	assign kbcode  = {1'b0, key_latch.shift, key_latch.code};
	assign skstat  = {2'b00, overrun, 2'b00, key_depr, 2'b00};  // bit 5 and bit 2

	a_credit_max: assert property (
		@(posedge o2) disable iff (!arst_n)
		credit_cnt <= CRED_MAX
	) else $error("key credit count above buffer depth");

	// event pulse lags the send decision by one edge
	a_evt_has_credit: assert property (
		@(posedge o2) disable iff (!arst_n)
		key_evt_valid |-> ($past(credit_cnt) != '0)
	) else $error("key event sent with no credit");

endmodule

// File: pots/pokey_pot_scan.sv
`include "pokey_defines.svh"

module pokey_pot_scan (
	input  logic                                  o2,
	input  logic                                  arst_n,
	input  pokey_ctrl_pkg::scan_ctl_t             scan_ctl,
	input  logic [`POKEY_POT_COUNT-1:0]           pot_scan,  // high once the pot cap charges
	output logic [`POKEY_POT_COUNT-1:0][7:0]      pot_val,
	output logic [`POKEY_POT_COUNT-1:0]           allpot
);

	localparam logic [7:0] POT_LIMIT = 8'(`POKEY_POT_LIMIT);

	logic [`POKEY_POT_COUNT-1:0] running;  // counter still live

	// counter doubles as the latched pot value once frozen
	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			pot_val <= '0;
			running <= '0;
		end else if (scan_ctl.potgo) begin
			pot_val <= '0;  // dump caps and restart all lines
			running <= '1;
		end else begin
			for (int i = 0; i < `POKEY_POT_COUNT; i++) begin
				if (running[i]) begin
					if (pot_scan[i]) begin
						running[i] <= 1'b0;  // line up, freeze count
					end else begin
						pot_val[i] <= pot_val[i] + 8'd1;
						// stop on reaching the limit
						if (pot_val[i] == POT_LIMIT - 8'd1)
							running[i] <= 1'b0;
					end
				end
			end
		end
	end

	assign allpot = running;

	for (genvar g = 0; g < `POKEY_POT_COUNT; g++) begin : g_pot_chk
		a_pot_limit: assert property (
			@(posedge o2) disable iff (!arst_n)
			pot_val[g] <= POT_LIMIT
		) else $error("pot counter %0d past limit", g);
	end

endmodule

// File: logic/pokey_read_mux.sv
`include "pokey_defines.svh"

module pokey_read_mux (
	input  logic                             o2,
	input  logic                             arst_n,
	input  pokey_bus_pkg::rd_reg_e           rd_sel,   // last read address
	input  logic [`POKEY_POT_COUNT-1:0][7:0] pot_val,
	input  logic [`POKEY_POT_COUNT-1:0]      allpot,
	input  logic [7:0]                       kbcode,
	input  logic [7:0]                       skstat,
	output logic [7:0]                       rdata
);

	logic [7:0] rd_val;

	always_comb begin
		case (rd_sel)
			pokey_bus_pkg::RD_POT0:   rd_val = pot_val[0];
			pokey_bus_pkg::RD_POT1:   rd_val = pot_val[1];
			pokey_bus_pkg::RD_ALLPOT: rd_val = 8'(allpot);  // unused lines read 0
			pokey_bus_pkg::RD_KBCODE: rd_val = kbcode;
			pokey_bus_pkg::RD_SKSTAT: rd_val = skstat;
			default:                  rd_val = 8'h00;  // unmapped reads
		endcase
	end

	// select only moves on a read, so rdata stays on that register
	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n)
			rdata <= 8'h00;
		else
			rdata <= rd_val;
	end

endmodule

// File: logic/pokey_top.sv
`include "pokey_defines.svh"

module pokey_top (
	input  logic                            o2,          // phase 2 clock
	input  logic                            arst_n,
	input  pokey_bus_pkg::bus_req_t         bus,
	output logic [7:0]                      rdata,
	output logic [5:0]                      key_scan,    // to the controller matrix
	input  logic                            kr1_n,
	input  logic                            shift_n,
	input  logic [`POKEY_POT_COUNT-1:0]     pot_scan,
	output logic                            key_evt_valid,
	output pokey_ctrl_pkg::key_evt_t        key_evt,
	input  logic                            key_credit
);

	pokey_ctrl_pkg::scan_ctl_t        scan_ctl;
	pokey_bus_pkg::rd_reg_e           rd_sel;
	logic [7:0]                       kbcode;
	logic [7:0]                       skstat;
	logic [`POKEY_POT_COUNT-1:0][7:0] pot_val;
	logic [`POKEY_POT_COUNT-1:0]      allpot;

	pokey_reg_decode u_decode (
		.o2       (o2),
		.arst_n   (arst_n),
		.bus      (bus),
		.scan_ctl (scan_ctl),
		.rd_sel   (rd_sel)
	);

	pokey_key_scan u_key_scan (
		.o2            (o2),
		.arst_n        (arst_n),
		.scan_ctl      (scan_ctl),
		.kr1_n         (kr1_n),
		.shift_n       (shift_n),
		.key_credit    (key_credit),
		.key_scan      (key_scan),
		.kbcode        (kbcode),
		.skstat        (skstat),
		.key_evt_valid (key_evt_valid),
		.key_evt       (key_evt)
	);

	pokey_pot_scan u_pot_scan (
		.o2       (o2),
		.arst_n   (arst_n),
		.scan_ctl (scan_ctl),
		.pot_scan (pot_scan),
		.pot_val  (pot_val),
		.allpot   (allpot)
	);

	pokey_read_mux u_read_mux (
		.o2      (o2),
		.arst_n  (arst_n),
		.rd_sel  (rd_sel),
		.pot_val (pot_val),
		.allpot  (allpot),
		.kbcode  (kbcode),
		.skstat  (skstat),
		.rdata   (rdata)
	);

endmodule

// File: verification/pokey_tb.sv
`include "pokey_defines.svh"

module pokey_tb;

	// 14 key presses and 2 pot runs, plus half again
	localparam int CYCLE_LIMIT = (14 * 256 + 2 * 240) * 3 / 2;

	logic                        o2;
	logic                        arst_n;
	pokey_bus_pkg::bus_req_t     bus;
	logic [7:0]                  rdata;
	logic [5:0]                  key_scan;
	logic                        kr1_n;
	logic                        shift_n;
	logic [`POKEY_POT_COUNT-1:0] pot_scan;
	logic                        key_evt_valid;
	pokey_ctrl_pkg::key_evt_t    key_evt;
	logic                        key_credit;

	logic [15:0]              lfsr;
	int                       cycles, checks, errors, tests, test_err;
	int                       evt_cnt;      // events seen so far
	pokey_ctrl_pkg::key_evt_t last_evt;
	int                       credits;      // reference credit count
	logic                     exp_overrun;
	logic                     key_down;
	logic [5:0]               held_code;
	logic                     pots_live;
	int                       pot_n;        // edges since POTGO
	int                       read_n;       // pot_n when the read was sampled
	int                       release_at [`POKEY_POT_COUNT];

	pokey_top dut (.*);

	initial begin
		o2 = 1'b0;
		forever #2 o2 = ~o2;
	end

	always @(posedge o2) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a test never finished", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// galois lfsr, taps 16,14,13,11
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(next_bit());
		return v;
	endfunction

	// one o2 cycle, then sample outputs and drive the keyboard and paddle models
	task automatic tick();
		logic cred_in;
		cred_in = key_credit;  // value the DUT sees on this edge
		@(posedge o2);
		#1;
		if (key_evt_valid) begin
			if (credits == 0) begin
				errors++;
				$display("ERROR at %0t: key event sent with no credit left", $time);
			end
			evt_cnt++;
			last_evt = key_evt;
		end
		credits = credits - int'(key_evt_valid) + int'(cred_in);
		if (credits > `POKEY_KEY_CREDITS)
			credits = `POKEY_KEY_CREDITS;  // extra returns dropped
		kr1_n = !(key_down && key_scan == held_code);  // single key matrix
		if (pots_live) begin
			pot_n++;
			for (int i = 0; i < `POKEY_POT_COUNT; i++)
				pot_scan[i] = (pot_n >= release_at[i]);  // cap charged, line up
		end
	endtask

	task automatic expect_eq(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
		bus.sel     = 1'b1;
		bus.we      = 1'b1;
		bus.addr.wr = pokey_bus_pkg::wr_reg_e'(addr);
		bus.wdata   = data;
		tick();
		bus = '0;
	endtask

	// rdata is valid one cycle after the request
	task automatic read_reg(input logic [3:0] addr);
		bus.sel     = 1'b1;
		bus.we      = 1'b0;
		bus.addr.rd = pokey_bus_pkg::rd_reg_e'(addr);
		tick();
		read_n = pot_n;
		bus = '0;
		tick();
	endtask

	task automatic check_reg(input logic [3:0] addr, input int exp, input string what);
		read_reg(addr);
		expect_eq(what, int'(rdata), exp);
	endtask

	task automatic return_credit();
		key_credit = 1'b1;
		tick();
		key_credit = 1'b0;
	endtask

	task automatic press_key(input logic [5:0] code, input logic shift);
		int  start;
		int  waited;
		logic want_evt;
		want_evt  = (credits > 0);
		start     = evt_cnt;
		waited    = 0;
		held_code = code;
		key_down  = 1'b1;
		shift_n   = ~shift;
		// accept lands within 3 scans, 4 allowed
		while (evt_cnt == start && waited < 256) begin
			tick();
			waited++;
		end
		if (!want_evt) begin
			exp_overrun = 1'b1;  // accepted with the buffer full
		end else if (evt_cnt == start) begin
			errors++;
			$display("no key event for code %0d within four scans", code);
		end else begin
			expect_eq("event code", int'(last_evt.code), int'(code));
			expect_eq("event shift", int'(last_evt.shift), int'(shift));
		end
		check_reg(`POKEY_ADDR_KBCODE, int'({1'b0, shift, code}), "KBCODE");
		check_reg(`POKEY_ADDR_SKSTAT, int'({2'b00, exp_overrun, 5'b00100}), "SKSTAT held");
		key_down = 1'b0;
		shift_n  = 1'b1;
		repeat (128) tick();  // a clean full scan clears key_depr
		check_reg(`POKEY_ADDR_SKSTAT, int'({2'b00, exp_overrun, 5'b00000}), "SKSTAT released");
	endtask

	task automatic run_pots(input logic hold_last);
		int         pick;
		logic [7:0] exp_all;
		for (int i = 0; i < `POKEY_POT_COUNT; i++)
			release_at[i] = rand_bits(8) % `POKEY_POT_LIMIT;
		if (hold_last)
			release_at[`POKEY_POT_COUNT-1] = 1000;  // never rises
		pick      = rand_bits(7);
		pot_n     = -1;  // POTGO edge becomes edge 0
		pots_live = 1'b1;
		bus_write(`POKEY_ADDR_POTGO, 8'h00);
		repeat (pick) tick();
		read_reg(`POKEY_ADDR_ALLPOT);
		exp_all = '0;
		for (int i = 0; i < `POKEY_POT_COUNT; i++)
			exp_all[i] = (release_at[i] >= `POKEY_POT_LIMIT) ?
				(read_n < `POKEY_POT_LIMIT) : (read_n <= release_at[i]);
		expect_eq("ALLPOT while counting", int'(rdata), int'(exp_all));
		while (pot_n < 230)
			tick();
		for (int i = 0; i < `POKEY_POT_COUNT; i++)
			check_reg(4'(`POKEY_ADDR_POT0 + i), (release_at[i] >= `POKEY_POT_LIMIT) ?
				`POKEY_POT_LIMIT : release_at[i], "pot count");
		check_reg(`POKEY_ADDR_ALLPOT, 0, "ALLPOT after run");
		pots_live = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		logic [5:0] frozen;
		int         start;
		bus         = '0;
		kr1_n       = 1'b1;
		shift_n     = 1'b1;
		pot_scan    = '0;
		key_credit  = 1'b0;
		arst_n      = 1'b0;
		lfsr        = 16'd35;
		credits     = `POKEY_KEY_CREDITS;
		exp_overrun = 1'b0;
		key_down    = 1'b0;
		held_code   = '0;
		pots_live   = 1'b0;
		pot_n       = 0;
		repeat (3) tick();
		arst_n = 1'b1;

		check_reg(`POKEY_ADDR_POT0, 0, "POT0");
		check_reg(`POKEY_ADDR_POT1, 0, "POT1");
		check_reg(`POKEY_ADDR_ALLPOT, 0, "ALLPOT");
		check_reg(`POKEY_ADDR_KBCODE, 0, "KBCODE");
		check_reg(`POKEY_ADDR_SKSTAT, 0, "SKSTAT");
		expect_eq("events after reset", evt_cnt, 0);
		end_test("reset state");

		for (int n = 0; n < 8; n++) begin
			press_key(6'(rand_bits(6)), 1'(rand_bits(1)));
			return_credit();
		end
		end_test("key acceptance");

		// third key finds both slots taken
		for (int n = 0; n < 3; n++)
			press_key(6'(rand_bits(6)), 1'(rand_bits(1)));
		return_credit();
		return_credit();
		bus_write(`POKEY_ADDR_SKRES, 8'h00);
		exp_overrun = 1'b0;
		check_reg(`POKEY_ADDR_SKSTAT, 0, "SKSTAT after SKRES");
		press_key(6'(rand_bits(6)), 1'(rand_bits(1)));
		return_credit();
		end_test("credit back-pressure");

		run_pots(1'b0);
		run_pots(1'b1);
		end_test("pot counting");

		bus_write(`POKEY_ADDR_SKCTL, 8'h00);
		frozen    = key_scan;
		start     = evt_cnt;
		held_code = 6'(rand_bits(6));
		key_down  = 1'b1;
		repeat (256) tick();
		expect_eq("key_scan while disabled", int'(key_scan), int'(frozen));
		expect_eq("events while disabled", evt_cnt - start, 0);
		key_down = 1'b0;
		bus_write(`POKEY_ADDR_SKCTL, 8'h01);
		press_key(held_code, 1'(rand_bits(1)));
		return_credit();
		end_test("key enable");

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: all.f
+incdir+common
common/pokey_bus_pkg.sv
common/pokey_ctrl_pkg.sv
logic/pokey_reg_decode.sv
keyboard/pokey_key_scan.sv
pots/pokey_pot_scan.sv
logic/pokey_read_mux.sv
logic/pokey_top.sv
verification/pokey_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = pokey_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
